// File: hdl/fetch_pkg.sv
package fetch_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] pair_t;

  localparam addr_t reset_pc = 32'h0000_0000;

  // Size of the instruction memory in 32-bit words.
  localparam int imem_words = 1024;

  typedef enum logic [1:0] {
    idle,
    busy,
    ctrl,
    inv
  } fetch_state_t;

  typedef struct packed {
    logic  valid;
    logic  spec;
    logic  fence;
    addr_t addr;
  } imem_req_t;

  typedef struct packed {
    logic  ready;
    pair_t rdata;
  } imem_rsp_t;

  // Resolved branch coming back from the backend with the prediction it was fetched under.
  typedef struct packed {
    logic  valid;
    addr_t pc;
    addr_t target;
    logic  taken;
    logic  pred_taken;
    addr_t pred_target;
  } btac_upd_t;

  typedef struct packed {
    logic  pred_branch;
    addr_t pred_pc;
    addr_t pred_baddr;
    logic  pred_miss;
    addr_t pred_maddr;
  } btac_out_t;

  typedef struct packed {
    logic  trap;
    logic  mret;
    addr_t mtvec;
    addr_t mepc;
  } csr_out_t;

  typedef struct packed {
    logic  ready;
    addr_t pc;
    pair_t rdata;
    logic  taken;
    addr_t taddr;
    addr_t tpc;
  } fetch_out_t;

endpackage

// File: hdl/btac.sv
`timescale 1ns/100ps

module btac #(
  parameter int BTAC_ENTRIES = 16
) (
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_pkg::addr_t     lookup_pc,
  input  fetch_pkg::btac_upd_t upd,
  output fetch_pkg::btac_out_t btac_out
);

  localparam int IW = $clog2(BTAC_ENTRIES);
  localparam int TW = 32 - 3 - IW;

  typedef logic [IW-1:0] index_t;
  typedef logic [TW-1:0] tag_t;

  logic [BTAC_ENTRIES-1:0] valid;
  tag_t                    tag    [BTAC_ENTRIES];
  logic                    slot   [BTAC_ENTRIES];
  fetch_pkg::addr_t        target [BTAC_ENTRIES];

  index_t rd_index;
  index_t wr_index;
  logic   hit;

  // A line covers one fetch pair; the slot bit records which word holds the branch.
  assign rd_index = lookup_pc[3 +: IW];
  assign wr_index = upd.pc[3 +: IW];
  assign hit      = valid[rd_index] && (tag[rd_index] == lookup_pc[31 -: TW]);

  always_comb begin
    btac_out.pred_branch = hit;
    btac_out.pred_pc     = {tag[rd_index], rd_index, slot[rd_index], 2'b00};
    btac_out.pred_baddr  = target[rd_index];

    btac_out.pred_miss = upd.valid &&
                         ((upd.taken != upd.pred_taken) ||
                          (upd.taken && (upd.target != upd.pred_target)));

    btac_out.pred_maddr = upd.taken ? upd.target : upd.pc + 32'd4;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid <= '0;
    end else if (upd.valid) begin
      valid[wr_index] <= upd.taken;
    end
  end

  always_ff @(posedge clock) begin
    if (upd.valid && upd.taken) begin
      tag[wr_index]    <= upd.pc[31 -: TW];
      slot[wr_index]   <= upd.pc[2];
      target[wr_index] <= upd.target;
    end
  end

endmodule

// File: hdl/itim.sv
`timescale 1ns/100ps

module itim #(
  parameter int MEM_LATENCY = 2
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 load_en,
  input  fetch_pkg::addr_t     load_addr,
  input  fetch_pkg::word_t     load_data,
  input  fetch_pkg::imem_req_t imem_req,
  output fetch_pkg::imem_rsp_t imem_rsp
);

  localparam int AW = $clog2(fetch_pkg::imem_words);
  localparam int CW = $clog2(MEM_LATENCY + 1);

  typedef logic [CW-1:0] count_t;

  fetch_pkg::word_t mem [fetch_pkg::imem_words];

  count_t        count;
  logic [AW-2:0] pair_q;
  logic          accept;

  // A plain request is taken once the current read is done or finishing.
  // Spec and fence requests abort whatever is in flight.
  assign accept = imem_req.valid &&
                  ((count <= count_t'(1)) || imem_req.spec || imem_req.fence);

  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[load_addr[AW+1:2]] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
    end else if (accept) begin
      count <= count_t'(MEM_LATENCY);
    end else if (count != '0) begin
      count <= count - count_t'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pair_q <= imem_req.addr[AW+1:3];
    end
  end

  always_comb begin
    imem_rsp.ready = (count == count_t'(1));
    imem_rsp.rdata = {mem[{pair_q, 1'b1}], mem[{pair_q, 1'b0}]};
  end

endmodule

// File: hdl/csr_regs.sv
`timescale 1ns/100ps

module csr_regs (
  input  logic                clock,
  input  logic                reset,
  input  logic                csr_we,
  input  logic                csr_sel,
  input  fetch_pkg::addr_t    csr_wdata,
  input  logic                trap,
  input  logic                mret,
  input  fetch_pkg::addr_t    fetch_pc,
  output fetch_pkg::csr_out_t csr_out
);

  fetch_pkg::addr_t mtvec;
  fetch_pkg::addr_t mepc;

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtvec <= '0;
    end else if (csr_we && !csr_sel) begin
      mtvec <= csr_wdata;
    end
  end

  // The trap return address takes precedence over a config write.
  always_ff @(posedge clock) begin
    if (!reset) begin
      mepc <= '0;
    end else if (trap) begin
      mepc <= fetch_pc;
    end else if (csr_we && csr_sel) begin
      mepc <= csr_wdata;
    end
  end

  always_comb begin
    csr_out.trap  = trap;
    csr_out.mret  = mret;
    csr_out.mtvec = mtvec;
    csr_out.mepc  = mepc;
  end

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::csr_out_t   csr_out,
  input  fetch_pkg::btac_out_t  btac_out,
  input  logic                  fence,
  input  fetch_pkg::addr_t      fence_npc,
  input  fetch_pkg::imem_rsp_t  imem_rsp,
  output fetch_pkg::imem_req_t  imem_req,
  output fetch_pkg::addr_t      fetch_pc,
  output fetch_pkg::fetch_out_t fetch_out
);

  fetch_pkg::fetch_state_t state;
  fetch_pkg::fetch_state_t state_nxt;
  fetch_pkg::addr_t        pc;
  fetch_pkg::addr_t        pc_nxt;
  fetch_pkg::fetch_out_t   out_q;
  fetch_pkg::fetch_out_t   out_nxt;

  logic stall;
  logic ready;
  logic valid;
  logic spec;
  logic fence_req;

  always_comb begin
    state_nxt = state;
    pc_nxt    = pc;
    valid     = 1'b0;
    spec      = 1'b0;
    fence_req = 1'b0;
    ready     = imem_rsp.ready;

    // The PC may only step forward in the cycle its own response comes back.
    stall = (state != fetch_pkg::busy) || !imem_rsp.ready;

    out_nxt       = '0;
    out_nxt.pc    = pc;
    out_nxt.rdata = imem_rsp.rdata;

    if (csr_out.trap) begin
      spec   = 1'b1;
      pc_nxt = csr_out.mtvec;
    end else if (csr_out.mret) begin
      spec   = 1'b1;
      pc_nxt = csr_out.mepc;
    end else if (btac_out.pred_miss) begin
      spec   = 1'b1;
      pc_nxt = btac_out.pred_maddr;
    end else if (fence) begin
      fence_req = 1'b1;
      pc_nxt    = fence_npc;
    end else if (btac_out.pred_branch && !stall) begin
      spec          = 1'b1;
      pc_nxt        = btac_out.pred_baddr;
      out_nxt.taken = 1'b1;
      out_nxt.taddr = btac_out.pred_baddr;
      out_nxt.tpc   = btac_out.pred_pc;
    end else if (!stall) begin
      pc_nxt = pc + 32'd8;
    end

    case (state)
      fetch_pkg::idle: begin
        state_nxt = fetch_pkg::busy;
        valid     = 1'b1;
      end
      fetch_pkg::busy: begin
        if (ready) begin
          valid = 1'b1;
        end else if (spec) begin
          state_nxt = fetch_pkg::ctrl;
        end else if (fence_req) begin
          state_nxt = fetch_pkg::inv;
        end
      end
      fetch_pkg::ctrl: begin
        // The response arriving here belongs to the aborted read.
        if (ready) begin
          state_nxt = fetch_pkg::busy;
          valid     = 1'b1;
        end
        ready = 1'b0;
      end
      fetch_pkg::inv: begin
        if (ready) begin
          state_nxt = fetch_pkg::busy;
          valid     = 1'b1;
          fence_req = 1'b1;
        end
        ready = 1'b0;
      end
      default: begin
        state_nxt = fetch_pkg::idle;
      end
    endcase

    out_nxt.ready = ready;

    imem_req.valid = valid;
    imem_req.spec  = spec;
    imem_req.fence = fence_req;
    imem_req.addr  = pc_nxt;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= fetch_pkg::idle;
      pc    <= fetch_pkg::reset_pc;
      out_q <= '0;
    end else begin
      state <= state_nxt;
      pc    <= pc_nxt;
      out_q <= out_nxt;
    end
  end

  assign fetch_pc  = pc;
  assign fetch_out = out_q;

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
  parameter int BTAC_ENTRIES = 16,
  parameter int MEM_LATENCY  = 2
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  load_en,
  input  fetch_pkg::addr_t      load_addr,
  input  fetch_pkg::word_t      load_data,
  input  logic                  csr_we,
  input  logic                  csr_sel,
  input  fetch_pkg::addr_t      csr_wdata,
  input  logic                  trap,
  input  logic                  mret,
  input  logic                  fence,
  input  fetch_pkg::addr_t      fence_npc,
  input  fetch_pkg::btac_upd_t  upd,
  output fetch_pkg::fetch_out_t fetch_out
);

  fetch_pkg::imem_req_t imem_req;
  fetch_pkg::imem_rsp_t imem_rsp;
  fetch_pkg::btac_out_t btac_out;
  fetch_pkg::csr_out_t  csr_out;
  fetch_pkg::addr_t     fetch_pc;

  fetch_stage u_fetch_stage (
    .clock     (clock),
    .reset     (reset),
    .csr_out   (csr_out),
    .btac_out  (btac_out),
    .fence     (fence),
    .fence_npc (fence_npc),
    .imem_rsp  (imem_rsp),
    .imem_req  (imem_req),
    .fetch_pc  (fetch_pc),
    .fetch_out (fetch_out)
  );

  btac #(
    .BTAC_ENTRIES (BTAC_ENTRIES)
  ) u_btac (
    .clock     (clock),
    .reset     (reset),
    .lookup_pc (fetch_pc),
    .upd       (upd),
    .btac_out  (btac_out)
  );

  itim #(
    .MEM_LATENCY (MEM_LATENCY)
  ) u_itim (
    .clock     (clock),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .imem_req  (imem_req),
    .imem_rsp  (imem_rsp)
  );

  csr_regs u_csr_regs (
    .clock     (clock),
    .reset     (reset),
    .csr_we    (csr_we),
    .csr_sel   (csr_sel),
    .csr_wdata (csr_wdata),
    .trap      (trap),
    .mret      (mret),
    .fetch_pc  (fetch_pc),
    .csr_out   (csr_out)
  );

endmodule

// File: dv/fetch_checker.sv
`timescale 1ns/100ps

module fetch_checker #(
  parameter int BTAC_ENTRIES = 16
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  load_en,
  input  fetch_pkg::addr_t      load_addr,
  input  fetch_pkg::word_t      load_data,
  input  logic                  csr_we,
  input  logic                  csr_sel,
  input  fetch_pkg::addr_t      csr_wdata,
  input  logic                  trap,
  input  logic                  mret,
  input  logic                  fence,
  input  fetch_pkg::addr_t      fence_npc,
  input  fetch_pkg::btac_upd_t  upd,
  input  fetch_pkg::fetch_out_t fetch_out,
  output int                    checks,
  output int                    errors
);

  fetch_pkg::word_t mem_model [fetch_pkg::imem_words];
  logic             bt_valid  [BTAC_ENTRIES];
  fetch_pkg::addr_t bt_pc     [BTAC_ENTRIES];
  fetch_pkg::addr_t bt_target [BTAC_ENTRIES];

  fetch_pkg::addr_t     exp_pc;
  fetch_pkg::addr_t     mtvec_model;
  fetch_pkg::addr_t     mepc_model;
  logic                 armed = 1'b0;

  // Backend inputs of the previous cycle line up with the fetch output visible now.
  logic                 last_trap;
  logic                 last_mret;
  logic                 last_fence;
  fetch_pkg::addr_t     last_npc;
  fetch_pkg::btac_upd_t last_upd;
  logic                 last_we;
  logic                 last_sel;
  fetch_pkg::addr_t     last_wdata;

  function automatic int btac_index(input fetch_pkg::addr_t pc);
    return int'(pc[31:3] % BTAC_ENTRIES);
  endfunction

  function automatic int pair_word(input fetch_pkg::addr_t pc);
    return int'(pc[31:3] % (fetch_pkg::imem_words / 2)) * 2;
  endfunction

  // Redirects in priority order, then a predicted branch, then the next pair.
  function automatic fetch_pkg::addr_t predict_next(
    input fetch_pkg::addr_t pc,
    input logic             done,
    input logic             hit,
    input fetch_pkg::addr_t btarget,
    input logic             miss,
    input fetch_pkg::addr_t maddr
  );
    if (last_trap) return mtvec_model;
    if (last_mret) return mepc_model;
    if (miss) return maddr;
    if (last_fence) return last_npc;
    if (!done) return pc;
    if (hit) return btarget;
    return pc + 32'd8;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  always @(posedge clock) begin
    int               idx;
    int               pw;
    logic             hit;
    logic             miss;
    logic             taken_exp;
    fetch_pkg::addr_t cur_pc;
    fetch_pkg::addr_t maddr;

    if (load_en) begin
      mem_model[int'(load_addr[31:2] % fetch_pkg::imem_words)] = load_data;
    end

    if (!reset) begin
      armed       = 1'b1;
      exp_pc      = fetch_pkg::reset_pc;
      mtvec_model = '0;
      mepc_model  = '0;
      checks      = 0;
      errors      = 0;
      for (int i = 0; i < BTAC_ENTRIES; i++) begin
        bt_valid[i] = 1'b0;
      end
    end else if (armed) begin
      cur_pc    = exp_pc;
      idx       = btac_index(cur_pc);
      hit       = bt_valid[idx] && (bt_pc[idx][31:3] == cur_pc[31:3]);
      miss      = last_upd.valid && ((last_upd.taken != last_upd.pred_taken) ||
                  (last_upd.taken && (last_upd.target != last_upd.pred_target)));
      maddr     = last_upd.taken ? last_upd.target : last_upd.pc + 32'd4;
      taken_exp = hit && !(last_trap || last_mret || miss || last_fence);

      if (fetch_out.ready) begin
        pw = pair_word(cur_pc);
        compare("fetch_out.pc", 64'(fetch_out.pc), 64'(cur_pc));
        compare("fetch_out.rdata", fetch_out.rdata, {mem_model[pw + 1], mem_model[pw]});
        compare("fetch_out.taken", 64'(fetch_out.taken), 64'(taken_exp));
        if (taken_exp) begin
          compare("fetch_out.taddr", 64'(fetch_out.taddr), 64'(bt_target[idx]));
          compare("fetch_out.tpc", 64'(fetch_out.tpc), 64'(bt_pc[idx]));
        end
      end

      exp_pc = predict_next(cur_pc, fetch_out.ready, hit, bt_target[idx], miss, maddr);

      if (last_trap) begin
        mepc_model = cur_pc;
      end else if (last_we && last_sel) begin
        mepc_model = last_wdata;
      end
      if (last_we && !last_sel) begin
        mtvec_model = last_wdata;
      end
      if (last_upd.valid) begin
        idx           = btac_index(last_upd.pc);
        bt_valid[idx] = last_upd.taken;
        if (last_upd.taken) begin
          bt_pc[idx]     = {last_upd.pc[31:2], 2'b00};
          bt_target[idx] = last_upd.target;
        end
      end
    end

    last_trap  = trap;
    last_mret  = mret;
    last_fence = fence;
    last_npc   = fence_npc;
    last_upd   = upd;
    last_we    = csr_we;
    last_sel   = csr_sel;
    last_wdata = csr_wdata;
  end

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

  localparam int btac_entries = 16;
  localparam int mem_latency  = 2;
  localparam int num_tests    = 6;
  localparam int period       = 20;
  // Each test gets 200 cycles, and loading the memory comes on top.
  localparam int watchdog_ns  = (num_tests * 200 + fetch_pkg::imem_words) * period;

  logic                  clock;
  logic                  reset;
  logic                  load_en;
  fetch_pkg::addr_t      load_addr;
  fetch_pkg::word_t      load_data;
  logic                  csr_we;
  logic                  csr_sel;
  fetch_pkg::addr_t      csr_wdata;
  logic                  trap;
  logic                  mret;
  logic                  fence;
  fetch_pkg::addr_t      fence_npc;
  fetch_pkg::btac_upd_t  upd;
  fetch_pkg::fetch_out_t fetch_out;
  int                    checks;
  int                    errors;
  int                    stalls;
  int                    passed;
  int                    failed;
  integer                seed = 32'he193;

  fetch_top #(
    .BTAC_ENTRIES (btac_entries),
    .MEM_LATENCY  (mem_latency)
  ) u_dut (
    .clock     (clock),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .csr_we    (csr_we),
    .csr_sel   (csr_sel),
    .csr_wdata (csr_wdata),
    .trap      (trap),
    .mret      (mret),
    .fence     (fence),
    .fence_npc (fence_npc),
    .upd       (upd),
    .fetch_out (fetch_out)
  );

  fetch_checker #(
    .BTAC_ENTRIES (btac_entries)
  ) u_checker (
    .clock     (clock),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .csr_we    (csr_we),
    .csr_sel   (csr_sel),
    .csr_wdata (csr_wdata),
    .trap      (trap),
    .mret      (mret),
    .fence     (fence),
    .fence_npc (fence_npc),
    .upd       (upd),
    .fetch_out (fetch_out),
    .checks    (checks),
    .errors    (errors)
  );

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before the tests finished", watchdog_ns);
    $display("Simulation failed");
    $finish;
  end

  task automatic load_memory();
    for (int i = 0; i < fetch_pkg::imem_words; i++) begin
      @(negedge clock);
      load_en   = 1'b1;
      load_addr = fetch_pkg::addr_t'(i * 4);
      load_data = $random(seed);
    end
    @(negedge clock);
    load_en = 1'b0;
  endtask

  // Waits for n fetch results and gives up after a bounded number of cycles.
  task automatic wait_fetches(input int n);
    int seen = 0;
    int cycles = 0;

    while (seen < n && cycles < 40 * n) begin
      @(posedge clock);
      cycles++;
      if (fetch_out.ready) begin
        seen++;
      end
    end
    if (seen < n) begin
      $display("Only %0d of %0d fetches completed within %0d cycles", seen, n, cycles);
      stalls++;
    end
  endtask

  function automatic fetch_pkg::btac_upd_t branch_update(
    input fetch_pkg::addr_t pc,
    input fetch_pkg::addr_t target,
    input logic             taken,
    input logic             pred_taken,
    input fetch_pkg::addr_t pred_target
  );
    fetch_pkg::btac_upd_t u;

    u.valid       = 1'b1;
    u.pc          = pc;
    u.target      = target;
    u.taken       = taken;
    u.pred_taken  = pred_taken;
    u.pred_target = pred_target;
    return u;
  endfunction

  task automatic drive_backend(input logic do_trap, input logic do_mret, input logic do_fence,
                               input fetch_pkg::addr_t npc, input fetch_pkg::btac_upd_t u);
    @(negedge clock);
    trap      = do_trap;
    mret      = do_mret;
    fence     = do_fence;
    fence_npc = npc;
    upd       = u;
    @(negedge clock);
    trap  = 1'b0;
    mret  = 1'b0;
    fence = 1'b0;
    upd   = '0;
  endtask

  task automatic write_csr(input logic sel, input fetch_pkg::addr_t data);
    @(negedge clock);
    csr_we    = 1'b1;
    csr_sel   = sel;
    csr_wdata = data;
    @(negedge clock);
    csr_we = 1'b0;
  endtask

  task automatic finish_test(input string name, input int mark);
    // The checker compares on the same edge, so its counts settle by the falling edge.
    @(negedge clock);
    if (errors + stalls == mark) begin
      passed++;
      $display("%s: pass", name);
    end else begin
      failed++;
      $display("%s: FAIL", name);
    end
  endtask

  initial begin
    int mark;

    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    csr_we    = 1'b0;
    csr_sel   = 1'b0;
    csr_wdata = '0;
    trap      = 1'b0;
    mret      = 1'b0;
    fence     = 1'b0;
    fence_npc = '0;
    upd       = '0;
    stalls    = 0;
    passed    = 0;
    failed    = 0;

    load_memory();
    reset = 1'b0;
    repeat (10) @(negedge clock);
    reset = 1'b1;

    mark = errors + stalls;
    wait_fetches(8);
    finish_test("sequential fetch", mark);

    mark = errors + stalls;
    drive_backend(1'b0, 1'b0, 1'b0, '0,
                  branch_update(fetch_out.pc + 32'd48, 32'h200, 1'b1, 1'b1, 32'h200));
    wait_fetches(10);
    finish_test("branch prediction", mark);

    mark = errors + stalls;
    drive_backend(1'b0, 1'b0, 1'b0, '0, branch_update(32'h100, 32'h300, 1'b1, 1'b0, 32'h0));
    wait_fetches(3);
    drive_backend(1'b0, 1'b0, 1'b0, '0, branch_update(32'h104, 32'h380, 1'b0, 1'b1, 32'h380));
    wait_fetches(3);
    finish_test("misprediction", mark);

    mark = errors + stalls;
    write_csr(1'b0, 32'h400);
    drive_backend(1'b1, 1'b0, 1'b0, '0, '0);
    wait_fetches(3);
    drive_backend(1'b0, 1'b1, 1'b0, '0, '0);
    wait_fetches(3);
    finish_test("trap and mret", mark);

    mark = errors + stalls;
    drive_backend(1'b0, 1'b0, 1'b1, 32'h500, '0);
    wait_fetches(3);
    finish_test("fence", mark);

    mark = errors + stalls;
    write_csr(1'b0, 32'h600);
    drive_backend(1'b1, 1'b0, 1'b1, 32'h700, branch_update(32'h120, 32'h780, 1'b1, 1'b0, 32'h0));
    wait_fetches(3);
    finish_test("redirect priority", mark);

    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             passed, failed, checks, errors);
    if (failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
hdl/fetch_pkg.sv
hdl/btac.sv
hdl/itim.sv
hdl/csr_regs.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f filelist.f --top-module fetch_tb -o fetch_sim
	@out="$$(./obj_dir/fetch_sim)"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
